//--- Makefile
# Verilator flow: lint the RTL top, build and run the testbench
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_drone_core
RTL_TOP    ?= drone_core
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation PASSED
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/angle_controller.sv
// ----------------------------------------------------------------------
// Angle loop for roll and pitch, direct yaw rate command
// Outputs register one cycle after imu_valid, flagged by ac_valid
// Targets beyond the rate_t range are held at its limits
// ----------------------------------------------------------------------
module angle_controller import drone_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetn,
	input  logic   imu_valid,
	input  stick_t throttle_stick,
	input  stick_t roll_stick,
	input  stick_t pitch_stick,
	input  stick_t yaw_stick,
	input  rate_t  roll_angle,
	input  rate_t  pitch_angle,
	output stick_t throttle_out,
	output rate_t  roll_target,
	output rate_t  pitch_target,
	output rate_t  yaw_target,
	output logic   ac_valid
);

	localparam int TGT_MAX = 2 ** ($bits(rate_t) - 1) - 1;
	localparam int TGT_MIN = -(2 ** ($bits(rate_t) - 1));

	// Centred stick minus measured angle, limited to rate_t
	function automatic rate_t axis_target(input stick_t stick, input rate_t angle);
		int diff;
		diff = int'(stick) - STICK_CENTER - int'(angle);
		if (diff > TGT_MAX)
			return rate_t'(TGT_MAX);
		if (diff < TGT_MIN)
			return rate_t'(TGT_MIN);
		return rate_t'(diff);
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!resetn)
			ac_valid <= 1'b0;
		else
			ac_valid <= imu_valid;
	end

	// Throttle is captured with the same sample to stay aligned
	always_ff @(posedge sys_clk) begin
		if (imu_valid) begin
			throttle_out <= throttle_stick;
			roll_target <= axis_target(roll_stick, roll_angle);
			pitch_target <= axis_target(pitch_stick, pitch_angle);
			// No yaw angle loop, so zero angle
			yaw_target <= axis_target(yaw_stick, rate_t'(0));
		end
	end

endmodule

//--- design/drone_core.sv
// ----------------------------------------------------------------------
// Flight-control datapath, receiver pulses and IMU samples to ESC pulses
// imu_valid to new motor rates is 3 cycles, pins follow at next frame
// IMU inputs are read only while imu_valid is high
// ----------------------------------------------------------------------
module drone_core import drone_pkg::*; #(
	parameter int CLK_PER_US = 4,
	parameter int FRAME_US = 2500,
	parameter int KP_SHIFT = 1
) (
	input  logic  sys_clk,
	input  logic  resetn,
	input  logic  throttle_pwm,
	input  logic  yaw_pwm,
	input  logic  roll_pwm,
	input  logic  pitch_pwm,
	input  logic  imu_valid,
	input  rate_t roll_angle,
	input  rate_t pitch_angle,
	input  rate_t roll_gyro,
	input  rate_t pitch_gyro,
	input  rate_t yaw_gyro,
	output logic  motor_1_pwm,
	output logic  motor_2_pwm,
	output logic  motor_3_pwm,
	output logic  motor_4_pwm
);

	logic us_tick;
	logic frame_start;
	stick_t throttle_val;
	stick_t yaw_val;
	stick_t roll_val;
	stick_t pitch_val;
	// Angle stage
	stick_t ac_throttle;
	rate_t roll_target;
	rate_t pitch_target;
	rate_t yaw_target;
	logic ac_valid;
	// Rate stage
	stick_t rc_throttle;
	rate_t roll_corr;
	rate_t pitch_corr;
	rate_t yaw_corr;
	logic rc_valid;
	// Mixer to ESC
	motor_t motor_1_rate;
	motor_t motor_2_rate;
	motor_t motor_3_rate;
	motor_t motor_4_rate;

	flight_timebase #(
		.CLK_PER_US(CLK_PER_US),
		.FRAME_US(FRAME_US)
	) i_timebase (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.frame_start(frame_start)
	);

	// One decoder per receiver channel
	rc_pulse_decoder i_throttle_dec (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.pulse(throttle_pwm),
		.value(throttle_val)
	);

	rc_pulse_decoder i_yaw_dec (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.pulse(yaw_pwm),
		.value(yaw_val)
	);

	rc_pulse_decoder i_roll_dec (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.pulse(roll_pwm),
		.value(roll_val)
	);

	rc_pulse_decoder i_pitch_dec (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.pulse(pitch_pwm),
		.value(pitch_val)
	);

	angle_controller i_angle (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.imu_valid(imu_valid),
		.throttle_stick(throttle_val),
		.roll_stick(roll_val),
		.pitch_stick(pitch_val),
		.yaw_stick(yaw_val),
		.roll_angle(roll_angle),
		.pitch_angle(pitch_angle),
		.throttle_out(ac_throttle),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_target(yaw_target),
		.ac_valid(ac_valid)
	);

	rate_controller #(
		.KP_SHIFT(KP_SHIFT)
	) i_rate (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.ac_valid(ac_valid),
		.throttle_in(ac_throttle),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_target(yaw_target),
		.roll_gyro(roll_gyro),
		.pitch_gyro(pitch_gyro),
		.yaw_gyro(yaw_gyro),
		.throttle_out(rc_throttle),
		.roll_corr(roll_corr),
		.pitch_corr(pitch_corr),
		.yaw_corr(yaw_corr),
		.rc_valid(rc_valid)
	);

	motor_mixer i_mixer (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.rc_valid(rc_valid),
		.throttle(rc_throttle),
		.roll_corr(roll_corr),
		.pitch_corr(pitch_corr),
		.yaw_corr(yaw_corr),
		.motor_1_rate(motor_1_rate),
		.motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate),
		.motor_4_rate(motor_4_rate)
	);

	esc_pwm i_esc (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.frame_start(frame_start),
		.motor_1_rate(motor_1_rate),
		.motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate),
		.motor_4_rate(motor_4_rate),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

endmodule

//--- design/drone_pkg.sv
// ----------------------------------------------------------------------
// Widths, types and flight constants shared by the control datapath
// Stick, throttle and motor values share one 0..250 scale
// Pulse counters cover up to 4095 us, enough for 1000..2000 us pulses
// ----------------------------------------------------------------------
package drone_pkg;

	// Receiver stick or throttle value, 0..STICK_MAX
	typedef logic [7:0] stick_t;

	// Signed axis quantity
	// IMU angles, gyro rates, rate targets and corrections all use this
	typedef logic signed [9:0] rate_t;

	// Motor rate handed to the ESC stage, 0..STICK_MAX
	typedef logic [7:0] motor_t;

	// Top of the stick and motor scale
	localparam int STICK_MAX = 250;
	// Neutral stick position
	localparam int STICK_CENTER = 125;

	// RC and ESC pulse width that maps to a value of 0
	localparam int PULSE_MIN_US = 1000;
	// Pulse width per unit step of value
	localparam int US_PER_STEP = 4;

	// Magnitude limit on the rate loop corrections
	localparam int RATE_LIMIT = 200;

	// Width of microsecond pulse counters
	localparam int PULSE_CNT_W = 12;

endpackage

//--- design/esc_pwm.sv
// ----------------------------------------------------------------------
// Four ESC pulse outputs, PULSE_MIN_US + US_PER_STEP * rate wide
// Rates sampled only at frame_start, outputs low until the first one
// Frame must be longer than the widest pulse (2000 us)
// ----------------------------------------------------------------------
module esc_pwm import drone_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetn,
	input  logic   us_tick,
	input  logic   frame_start,
	input  motor_t motor_1_rate,
	input  motor_t motor_2_rate,
	input  motor_t motor_3_rate,
	input  motor_t motor_4_rate,
	output logic   motor_1_pwm,
	output logic   motor_2_pwm,
	output logic   motor_3_pwm,
	output logic   motor_4_pwm
);

	localparam int NUM_MOTORS = 4;

	motor_t rate_q [NUM_MOTORS];
	logic [PULSE_CNT_W-1:0] width_us [NUM_MOTORS];
	logic [PULSE_CNT_W-1:0] us_cnt;
	logic [PULSE_CNT_W-1:0] us_next;
	logic [NUM_MOTORS-1:0] pwm_q;

	assign us_next = us_cnt + 1'b1;

	// Target pulse width per motor in microseconds
	always_comb begin
		for (int i = 0; i < NUM_MOTORS; i++)
			width_us[i] = PULSE_CNT_W'(PULSE_MIN_US + US_PER_STEP * int'(rate_q[i]));
	end

	// Rates frozen for the whole frame
	always_ff @(posedge sys_clk) begin
		if (frame_start) begin
			rate_q[0] <= motor_1_rate;
			rate_q[1] <= motor_2_rate;
			rate_q[2] <= motor_3_rate;
			rate_q[3] <= motor_4_rate;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			us_cnt <= '0;
			pwm_q <= '0;
		end else if (frame_start) begin
			us_cnt <= '0;
			pwm_q <= '1;
		end else begin
			// Shared counter stops at full scale between pulses
			if (us_tick && (us_cnt != '1))
				us_cnt <= us_next;
			// Drop on the tick that completes the width, exact in cycles
			for (int i = 0; i < NUM_MOTORS; i++) begin
				if (us_tick && pwm_q[i] && (us_next >= width_us[i]))
					pwm_q[i] <= 1'b0;
			end
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

endmodule

//--- design/flight_timebase.sv
// ----------------------------------------------------------------------
// Microsecond tick and ESC frame strobe from sys_clk
// CLK_PER_US must be a whole number of cycles per microsecond
// ----------------------------------------------------------------------
module flight_timebase #(
	parameter int CLK_PER_US = 4,
	parameter int FRAME_US = 2500
) (
	input  logic sys_clk,
	input  logic resetn,
	output logic us_tick,
	output logic frame_start
);

	localparam int CLK_W = $clog2(CLK_PER_US + 1);
	localparam int FRAME_W = $clog2(FRAME_US + 1);

	logic [CLK_W-1:0] clk_cnt;
	logic [FRAME_W-1:0] us_cnt;
	logic us_wrap;
	logic frame_wrap;

	// Last cycle of the current microsecond
	assign us_wrap = (clk_cnt == CLK_W'(CLK_PER_US - 1));
	// Last microsecond of the current frame
	assign frame_wrap = (us_cnt == FRAME_W'(FRAME_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			clk_cnt <= '0;
			us_cnt <= '0;
			us_tick <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			// Both strobes registered, so frame_start coincides with a tick
			us_tick <= us_wrap;
			frame_start <= us_wrap && frame_wrap;
			if (us_wrap) begin
				clk_cnt <= '0;
				if (frame_wrap)
					us_cnt <= '0;
				else
					us_cnt <= us_cnt + 1'b1;
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

//--- design/motor_mixer.sv
// ----------------------------------------------------------------------
// Quad-X mixer of throttle and axis corrections into four motor rates
// Rates register one cycle after rc_valid and hold until the next one
// ----------------------------------------------------------------------
module motor_mixer import drone_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetn,
	input  logic   rc_valid,
	input  stick_t throttle,
	input  rate_t  roll_corr,
	input  rate_t  pitch_corr,
	input  rate_t  yaw_corr,
	output motor_t motor_1_rate,
	output motor_t motor_2_rate,
	output motor_t motor_3_rate,
	output motor_t motor_4_rate
);

	int thr;
	int roll;
	int pitch;
	int yaw;

	// Clamp a signed sum onto the motor scale
	function automatic motor_t clamp_motor(input int sum);
		if (sum < 0)
			return '0;
		if (sum > STICK_MAX)
			return motor_t'(STICK_MAX);
		return motor_t'(sum);
	endfunction

	// Operands widened to signed int before mixing
	always_comb begin
		thr = int'(throttle);
		roll = int'(roll_corr);
		pitch = int'(pitch_corr);
		yaw = int'(yaw_corr);
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_1_rate <= '0;
			motor_2_rate <= '0;
			motor_3_rate <= '0;
			motor_4_rate <= '0;
		end else if (rc_valid) begin
			// Sign table    pitch  roll  yaw
			motor_1_rate <= clamp_motor(thr + pitch + roll - yaw);
			motor_2_rate <= clamp_motor(thr + pitch - roll + yaw);
			motor_3_rate <= clamp_motor(thr - pitch - roll - yaw);
			motor_4_rate <= clamp_motor(thr - pitch + roll + yaw);
		end
	end

endmodule

//--- design/rate_controller.sv
// ----------------------------------------------------------------------
// Proportional rate loop on roll, pitch and yaw
// Gain is a right shift by KP_SHIFT, results held within +-RATE_LIMIT
// Outputs register one cycle after ac_valid, flagged by rc_valid
// Gyro rates are used from the imu_valid cycle, one cycle before ac_valid
// ----------------------------------------------------------------------
module rate_controller import drone_pkg::*; #(
	parameter int KP_SHIFT = 1
) (
	input  logic   sys_clk,
	input  logic   resetn,
	input  logic   ac_valid,
	input  stick_t throttle_in,
	input  rate_t  roll_target,
	input  rate_t  pitch_target,
	input  rate_t  yaw_target,
	input  rate_t  roll_gyro,
	input  rate_t  pitch_gyro,
	input  rate_t  yaw_gyro,
	output stick_t throttle_out,
	output rate_t  roll_corr,
	output rate_t  pitch_corr,
	output rate_t  yaw_corr,
	output logic   rc_valid
);

	// Gyro rates one cycle late, lined up with ac_valid
	rate_t roll_gyro_q;
	rate_t pitch_gyro_q;
	rate_t yaw_gyro_q;

	// Error in int width so the subtraction cannot wrap
	function automatic rate_t correction(input rate_t target, input rate_t gyro);
		int err;
		int scaled;
		err = int'(target) - int'(gyro);
		// Arithmetic shift keeps the sign
		scaled = err >>> KP_SHIFT;
		if (scaled > RATE_LIMIT)
			return rate_t'(RATE_LIMIT);
		if (scaled < -RATE_LIMIT)
			return rate_t'(-RATE_LIMIT);
		return rate_t'(scaled);
	endfunction

	// Same IMU sample as the targets from the angle stage
	always_ff @(posedge sys_clk) begin
		roll_gyro_q <= roll_gyro;
		pitch_gyro_q <= pitch_gyro;
		yaw_gyro_q <= yaw_gyro;
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn)
			rc_valid <= 1'b0;
		else
			rc_valid <= ac_valid;
	end

	always_ff @(posedge sys_clk) begin
		if (ac_valid) begin
			throttle_out <= throttle_in;
			roll_corr <= correction(roll_target, roll_gyro_q);
			pitch_corr <= correction(pitch_target, pitch_gyro_q);
			yaw_corr <= correction(yaw_target, yaw_gyro_q);
		end
	end

endmodule

//--- design/rc_pulse_decoder.sv
// ----------------------------------------------------------------------
// Measures one RC receiver pulse and scales it to a 0..250 stick value
// Value updates 3 cycles after the input falls (2 sync flops + 1)
// Resolution is one us_tick, pulses outside 1000..2000 us saturate
// ----------------------------------------------------------------------
module rc_pulse_decoder import drone_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetn,
	input  logic   us_tick,
	input  logic   pulse,
	output stick_t value
);

	// [0] first sync flop, [1] synchronized pulse, [2] its previous value
	logic [2:0] pulse_sr;
	logic [PULSE_CNT_W-1:0] width_us;
	logic [PULSE_CNT_W-1:0] steps;
	logic falling;
	stick_t scaled;

	assign falling = pulse_sr[2] & ~pulse_sr[1];

	// Offset, divide and clamp of the measured width
	always_comb begin
		if (width_us <= PULSE_CNT_W'(PULSE_MIN_US))
			steps = '0;
		else
			steps = (width_us - PULSE_CNT_W'(PULSE_MIN_US)) / PULSE_CNT_W'(US_PER_STEP);
		if (steps > PULSE_CNT_W'(STICK_MAX))
			scaled = stick_t'(STICK_MAX);
		else
			scaled = stick_t'(steps);
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			pulse_sr <= '0;
			width_us <= '0;
			value <= '0;
		end else begin
			pulse_sr <= {pulse_sr[1:0], pulse};
			// Count while high, hold at full scale on very long pulses
			if (!pulse_sr[1])
				width_us <= '0;
			else if (us_tick && (width_us != '1))
				width_us <= width_us + 1'b1;
			// Count is still intact on the falling edge cycle
			if (falling)
				value <= scaled;
		end
	end

endmodule

//--- sim/drone_trace.txt
# thr_us yaw_us roll_us pitch_us roll_angle pitch_angle roll_gyro pitch_gyro yaw_gyro
# then expected m1_us m2_us m3_us m4_us, all decimal, one test per line
1400 1500 1500 1500 0 0 0 0 0 1400 1400 1400 1400
1600 1500 1500 1500 0 0 0 0 0 1600 1600 1600 1600
1400 1500 1600 1500 0 0 0 0 0 1448 1352 1352 1448
1400 1500 1500 1300 0 0 0 0 0 1300 1300 1500 1500
1500 1500 1700 1580 0 0 0 0 0 1640 1440 1360 1560
1400 1500 1500 1500 40 0 0 0 0 1320 1480 1480 1320
1400 1500 1500 1500 7 -31 0 0 0 1444 1476 1356 1324
1400 1700 1500 1500 0 0 0 0 -20 1260 1540 1260 1540
2000 1500 2000 1500 0 0 0 0 0 2000 1752 1752 2000
1040 1500 1500 1000 0 0 0 0 0 1000 1000 1292 1292
900 800 2200 1500 0 0 0 0 0 1500 1000 1004 1000
1500 1500 1500 1500 0 0 500 0 0 1000 2000 2000 1000
1500 1500 1500 1500 0 0 0 -480 450 2000 1500 1500 1000
1403 1500 1563 1500 0 0 0 0 0 1428 1372 1372 1428

//--- sim/tb_drone_core.sv
// ----------------------------------------------------------------------
// Trace-driven testbench for drone_core, run from the project root
// One trace line per test, receiver widths in, ESC widths expected
// ESC widths taken from the second full pulse after each IMU strobe
// ----------------------------------------------------------------------
module tb_drone_core import drone_pkg::*; ();

	localparam int CLK_PER_US = 4;
	localparam int FRAME_US = 2500;
	localparam int KP_SHIFT = 1;
	localparam int FRAME_CYCLES = CLK_PER_US * FRAME_US;
	// Idle time after the longest receiver pulse
	localparam int RX_GAP_US = 100;
	localparam int MAX_TESTS = 64;
	localparam int NUM_FIELDS = 13;
	// Two receiver frames, two ESC frames and the measured pulse fit easily
	localparam int FRAMES_PER_TEST = 6;
	localparam int MARGIN_CYCLES = 1000;
	localparam string TRACE_FILE = "sim/drone_trace.txt";
	// Value left on the IMU bus between strobes
	localparam int IMU_IDLE = -512;

	logic sys_clk;
	logic resetn;
	logic throttle_pwm;
	logic yaw_pwm;
	logic roll_pwm;
	logic pitch_pwm;
	logic imu_valid;
	rate_t roll_angle;
	rate_t pitch_angle;
	rate_t roll_gyro;
	rate_t pitch_gyro;
	rate_t yaw_gyro;
	logic motor_1_pwm;
	logic motor_2_pwm;
	logic motor_3_pwm;
	logic motor_4_pwm;
	logic [3:0] motor_pwm;

	// Trace columns as listed in the trace file header
	int trace [MAX_TESTS][NUM_FIELDS];
	int high_cycles [4];
	int num_tests;
	int errors;
	int checks;
	logic trace_ready;

	assign motor_pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

	drone_core #(
		.CLK_PER_US(CLK_PER_US),
		.FRAME_US(FRAME_US),
		.KP_SHIFT(KP_SHIFT)
	) i_dut (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(throttle_pwm),
		.yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.imu_valid(imu_valid),
		.roll_angle(roll_angle),
		.pitch_angle(pitch_angle),
		.roll_gyro(roll_gyro),
		.pitch_gyro(pitch_gyro),
		.yaw_gyro(yaw_gyro),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	function automatic int max_of(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic read_trace();
		int fd;
		int n;
		int code;
		string line;
		int f [NUM_FIELDS];
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Error: cannot open trace file %s", TRACE_FILE);
			errors++;
			return;
		end
		while (!$feof(fd) && num_tests < MAX_TESTS) begin
			code = $fgets(line, fd);
			// Comment and blank lines
			if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6],
				f[7], f[8], f[9], f[10], f[11], f[12]);
			if (n != NUM_FIELDS) begin
				$display("Error: malformed trace line: %s", line);
				errors++;
			end else begin
				for (int k = 0; k < NUM_FIELDS; k++)
					trace[num_tests][k] = f[k];
				num_tests++;
			end
		end
		$fclose(fd);
	endtask

	// All four channels rise together, each falls after its own width
	task automatic send_rx_frame(input int thr_us, input int yaw_us, input int roll_us,
		input int pitch_us);
		int len;
		len = max_of(max_of(thr_us, yaw_us), max_of(roll_us, pitch_us));
		len = (len + RX_GAP_US) * CLK_PER_US;
		@(posedge sys_clk);
		throttle_pwm <= 1'b1;
		yaw_pwm <= 1'b1;
		roll_pwm <= 1'b1;
		pitch_pwm <= 1'b1;
		for (int cyc = 1; cyc < len; cyc++) begin
			@(posedge sys_clk);
			if (cyc >= thr_us * CLK_PER_US)
				throttle_pwm <= 1'b0;
			if (cyc >= yaw_us * CLK_PER_US)
				yaw_pwm <= 1'b0;
			if (cyc >= roll_us * CLK_PER_US)
				roll_pwm <= 1'b0;
			if (cyc >= pitch_us * CLK_PER_US)
				pitch_pwm <= 1'b0;
		end
	endtask

	// One-cycle IMU sample, bus left at a junk value afterwards
	task automatic send_imu(input int ra, input int pa, input int rg, input int pg,
		input int yg);
		@(posedge sys_clk);
		imu_valid <= 1'b1;
		roll_angle <= rate_t'(ra);
		pitch_angle <= rate_t'(pa);
		roll_gyro <= rate_t'(rg);
		pitch_gyro <= rate_t'(pg);
		yaw_gyro <= rate_t'(yg);
		@(posedge sys_clk);
		imu_valid <= 1'b0;
		roll_angle <= rate_t'(IMU_IDLE);
		pitch_angle <= rate_t'(IMU_IDLE);
		roll_gyro <= rate_t'(IMU_IDLE);
		pitch_gyro <= rate_t'(IMU_IDLE);
		yaw_gyro <= rate_t'(IMU_IDLE);
	endtask

	// Returns on the first edge that samples a new ESC pulse high
	task automatic wait_esc_rise();
		@(posedge sys_clk);
		while (motor_1_pwm)
			@(posedge sys_clk);
		while (!motor_1_pwm)
			@(posedge sys_clk);
	endtask

	// High time in cycles of all four outputs, which rise together
	task automatic measure_pulses();
		for (int m = 0; m < 4; m++)
			high_cycles[m] = 0;
		while (motor_pwm != 4'b0000) begin
			for (int m = 0; m < 4; m++) begin
				if (motor_pwm[m])
					high_cycles[m]++;
			end
			@(posedge sys_clk);
		end
	endtask

	task automatic run_test(input int idx);
		int exp_us;
		string name;
		// Two identical receiver frames so every stick value is settled
		send_rx_frame(trace[idx][0], trace[idx][1], trace[idx][2], trace[idx][3]);
		send_rx_frame(trace[idx][0], trace[idx][1], trace[idx][2], trace[idx][3]);
		send_imu(trace[idx][4], trace[idx][5], trace[idx][6], trace[idx][7], trace[idx][8]);
		// First pulse may still carry the previous rates
		wait_esc_rise();
		wait_esc_rise();
		measure_pulses();
		for (int m = 0; m < 4; m++) begin
			exp_us = trace[idx][9 + m];
			name = $sformatf("motor_%0d_pwm width (test %0d)", m + 1, idx);
			if (exp_us < PULSE_MIN_US || exp_us > PULSE_MIN_US + US_PER_STEP * STICK_MAX) begin
				$display("Error: test %0d expects a motor %0d width of %0d us, out of range",
					idx, m + 1, exp_us);
				errors++;
			end else begin
				check_value(name, high_cycles[m] / CLK_PER_US, exp_us);
			end
		end
	endtask

	initial begin
		resetn = 1'b0;
		throttle_pwm = 1'b0;
		yaw_pwm = 1'b0;
		roll_pwm = 1'b0;
		pitch_pwm = 1'b0;
		imu_valid = 1'b0;
		roll_angle = '0;
		pitch_angle = '0;
		roll_gyro = '0;
		pitch_gyro = '0;
		yaw_gyro = '0;
		errors = 0;
		checks = 0;
		num_tests = 0;
		trace_ready = 1'b0;
		read_trace();
		if (num_tests == 0) begin
			$display("Error: no tests found in the trace file");
			errors++;
		end
		trace_ready = 1'b1;
		repeat (16) @(posedge sys_clk);
		resetn <= 1'b1;
		for (int i = 0; i < num_tests; i++)
			run_test(i);
		$display("Tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Limit scales with the number of trace lines
	initial begin
		wait (trace_ready);
		repeat ((num_tests * FRAMES_PER_TEST + 1) * FRAME_CYCLES + MARGIN_CYCLES)
			@(posedge sys_clk);
		$display("Error: run timed out before all %0d tests finished", num_tests);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- src.f
design/drone_pkg.sv
design/flight_timebase.sv
design/rc_pulse_decoder.sv
design/angle_controller.sv
design/rate_controller.sv
design/motor_mixer.sv
design/esc_pwm.sv
design/drone_core.sv
sim/tb_drone_core.sv
